// ==== verilog/nora_bus_pkg.sv ====
/*
 * NORA bus controller shared definitions
 * widths that carry a meaning, CPU region decode,
 * debug-master FSM states and the structs passed between blocks
 */
package nora_bus_pkg;

    // plain widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] cpu_addr_t;
    // low address lines shared by CPU and memory bus
    typedef logic [11:0] low_addr_t;
    // memory page, address bits 20:12
    typedef logic [8:0]  mem_page_t;
    typedef logic [7:0]  ram_bank_t;
    // bit 5 picks the boot ROM inside the FPGA
    typedef logic [5:0]  rom_bank_t;
    typedef logic [20:0] mst_addr_t;

    // target of a CPU bus cycle
    typedef enum logic [3:0] {
        REG_NONE,
        REG_SRAM,
        REG_BANKREG,
        REG_BOOTROM,
        REG_VIA1,
        REG_VERA,
        REG_AURA,
        REG_SCRB,
        REG_ENET
    } region_e;

    // debug-master access sequencer
    typedef enum logic [2:0] {
        MST_IDLE,
        MST_WAIT_CPU_STOP,
        MST_DISABLE_CPU_BUS,
        MST_SETUP_ACC,
        MST_EXT_ACC,
        MST_DATA_ACC,
        MST_FIN_ACC,
        MST_WAIT_REQ_LOW
    } mst_state_e;

    // one latched CPU cycle
    typedef struct packed {
        region_e   region;
        mem_page_t page;
        cpu_addr_t addr;
        logic      rwn;
    } cpu_cycle_t;

    // master ownership of the memory bus
    typedef struct packed {
        logic      active;
        logic      sram_sel;
        mem_page_t page;
        low_addr_t abl;
        logic      rwn;
    } mst_bus_t;

    // low CPU memory sits in SRAM pages 0x170..0x17F
    localparam logic [4:0] SRAM_LOW_BASE = 5'h17;
    // ROM banks live in the top quarter of SRAM
    localparam logic [1:0] ROM_BASE = 2'b11;
    localparam logic [7:0] IO_PAGE = 8'h9F;

endpackage

// ==== verilog/cpu_cycle_decode.sv ====
/*
 * CPU cycle decode
 * latches each CPU bus cycle on setup_cs and maps its address
 * to a target region and an SRAM page
 */
`timescale 1ns/1ps

module cpu_cycle_decode import nora_bus_pkg::*;
(
    input  logic         clk6x,
    input  logic         resetn,
    input  logic         setup_cs_i,
    input  logic         release_cs_i,
    input  logic [15:12] cpu_abh_i,
    input  low_addr_t    memcpu_abl_i,
    input  logic         cpu_rw_i,
    input  ram_bank_t    ram_bank_masked_i,
    input  rom_bank_t    rom_bank_i,
    output cpu_cycle_t   cycle_o
);

    cpu_addr_t cpu_ab;
    region_e   dec_region;
    mem_page_t dec_page;
    region_e   region_q;
    mem_page_t page_q;
    cpu_addr_t addr_q;
    logic      rwn_q;

    // full CPU address from the two halves
    assign cpu_ab = {cpu_abh_i, memcpu_abl_i};

    always_comb
    begin
        dec_region = REG_NONE;
        dec_page = '0;
        if (cpu_ab[15:1] == 15'h0000)
        begin
            // RAMBANK at 0x0000, ROMBANK at 0x0001
            dec_region = REG_BANKREG;
        end
        else if (cpu_abh_i[15:14] == 2'b11)
        begin
            // 16k ROM window at 0xC000
            if (rom_bank_i[5])
                dec_region = REG_BOOTROM;
            else
            begin
                dec_region = REG_SRAM;
                dec_page = {ROM_BASE, rom_bank_i[4:0], cpu_abh_i[13:12]};
            end
        end
        else if (cpu_abh_i[15:13] == 3'b101)
        begin
            // 8k RAM window at 0xA000, bank already masked
            dec_region = REG_SRAM;
            dec_page = {ram_bank_masked_i, cpu_abh_i[12]};
        end
        else if (cpu_ab[15:8] == IO_PAGE)
        begin
            // I/O area, one slot per 16 bytes
            case (cpu_ab[7:4])
                4'h0:       dec_region = REG_VIA1;
                4'h2, 4'h3: dec_region = REG_VERA;
                4'h4:       dec_region = REG_AURA;
                4'h5:       dec_region = REG_SCRB;
                4'h8:       dec_region = REG_ENET;
                default:    dec_region = REG_NONE;
            endcase
        end
        else
        begin
            // everything else is low memory
            dec_region = REG_SRAM;
            dec_page = {SRAM_LOW_BASE, cpu_abh_i};
        end
    end

    // region is the only control state, closed again by release_cs
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
            region_q <= REG_NONE;
        else if (setup_cs_i)
            region_q <= dec_region;
        else if (release_cs_i)
            region_q <= REG_NONE;
    end

    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            page_q <= dec_page;
            addr_q <= cpu_ab;
            rwn_q <= cpu_rw_i;
        end
    end

    assign cycle_o = '{region: region_q, page: page_q, addr: addr_q, rwn: rwn_q};

    // phaser opens and closes a cycle on different edges
    assert property (@(posedge clk6x) disable iff (!resetn)
        !(setup_cs_i && release_cs_i));

endmodule

// ==== verilog/bank_regs.sv ====
/*
 * Bank registers
 * RAMBANK at 0x0000 and ROMBANK at 0x0001, written by the CPU,
 * plus the masked RAM bank used by the decoder
 */
`timescale 1ns/1ps

module bank_regs import nora_bus_pkg::*;
(
    input  logic       clk6x,
    input  logic       resetn,
    input  logic       release_wr_i,
    input  byte_t      db_wr_i,
    input  cpu_cycle_t cycle_i,
    input  ram_bank_t  rambank_mask_i,
    output ram_bank_t  ram_bank_masked_o,
    output rom_bank_t  rom_bank_o,
    output byte_t      bank_rd_o
);

    ram_bank_t ram_bank;
    logic      bank_wr;

    // CPU write data is only stable by release_wr
    assign bank_wr = release_wr_i && (cycle_i.region == REG_BANKREG) && !cycle_i.rwn;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            ram_bank <= '0;
            rom_bank_o <= '0;
            ram_bank_masked_o <= '0;
        end
        else
        begin
            if (bank_wr)
            begin
                if (!cycle_i.addr[0])
                    ram_bank <= db_wr_i;
                else
                    rom_bank_o <= db_wr_i[5:0];
            end
            // masked copy ready before the next setup_cs
            ram_bank_masked_o <= ram_bank & rambank_mask_i;
        end
    end

    // unmasked value reads back, ROMBANK zero-extended
    assign bank_rd_o = cycle_i.addr[0] ? {2'b00, rom_bank_o} : ram_bank;

endmodule

// ==== verilog/master_access_fsm.sv ====
/*
 * Debug-master access sequencer
 * stops the CPU, takes over the memory bus for one SRAM access
 * and answers the master with a four-phase req/ack handshake
 */
`timescale 1ns/1ps

module master_access_fsm import nora_bus_pkg::*;
#(
    // memory access wait cycles, at least 1
    parameter int ACCESS_WAIT = 2
)
(
    input  logic      clk6x,
    input  logic      resetn,
    input  logic      req_i,
    input  mst_addr_t addr_i,
    input  logic      rwn_i,
    input  logic      stopped_cpu_i,
    input  byte_t     rd_data_i,
    output logic      run_cpu_o,
    output logic      cpu_be_o,
    output mst_bus_t  mst_o,
    output logic      ack_o,
    output byte_t     datard_o
);

    localparam int CNT_W = $clog2(ACCESS_WAIT + 1);

    mst_state_e       state;
    logic [CNT_W-1:0] wait_cnt;
    logic             mst_active;
    logic             mst_sram_sel;
    mem_page_t        mst_page;
    low_addr_t        mst_abl;
    logic             mst_rwn;
    logic             cpu_stop_seen;

    assign cpu_stop_seen = (state == MST_WAIT_CPU_STOP) && stopped_cpu_i;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            state <= MST_IDLE;
            run_cpu_o <= 1'b0;
            cpu_be_o <= 1'b1;
            ack_o <= 1'b0;
            mst_active <= 1'b0;
            mst_sram_sel <= 1'b0;
            wait_cnt <= '0;
        end
        else
        begin
            case (state)
                MST_IDLE:
                begin
                    run_cpu_o <= 1'b1;
                    // new request only while ack is low
                    if (req_i && !ack_o)
                    begin
                        run_cpu_o <= 1'b0;
                        state <= MST_WAIT_CPU_STOP;
                    end
                end
                MST_WAIT_CPU_STOP:
                begin
                    // phaser may take a while to finish the CPU cycle
                    if (cpu_stop_seen)
                    begin
                        mst_active <= 1'b1;
                        cpu_be_o <= 1'b0;
                        state <= MST_DISABLE_CPU_BUS;
                    end
                end
                MST_DISABLE_CPU_BUS:
                begin
                    // bus turnaround
                    state <= MST_SETUP_ACC;
                end
                MST_SETUP_ACC:
                begin
                    mst_sram_sel <= 1'b1;
                    wait_cnt <= CNT_W'(ACCESS_WAIT - 1);
                    state <= MST_EXT_ACC;
                end
                MST_EXT_ACC:
                begin
                    // SRAM access time
                    if (wait_cnt == '0)
                        state <= MST_DATA_ACC;
                    else
                        wait_cnt <= wait_cnt - 1'b1;
                end
                MST_DATA_ACC:
                begin
                    // strobes off, address and data still held
                    mst_sram_sel <= 1'b0;
                    state <= MST_FIN_ACC;
                end
                MST_FIN_ACC:
                begin
                    mst_active <= 1'b0;
                    cpu_be_o <= 1'b1;
                    ack_o <= 1'b1;
                    state <= MST_WAIT_REQ_LOW;
                end
                MST_WAIT_REQ_LOW:
                begin
                    if (!req_i)
                    begin
                        ack_o <= 1'b0;
                        run_cpu_o <= 1'b1;
                        state <= MST_IDLE;
                    end
                end
                default: state <= MST_IDLE;
            endcase
        end
    end

    // master address is held stable until ack, so latch it once
    always_ff @(posedge clk6x)
    begin
        if (cpu_stop_seen)
        begin
            mst_page <= addr_i[20:12];
            mst_abl <= addr_i[11:0];
            mst_rwn <= rwn_i;
        end
        if (state == MST_DATA_ACC)
            datard_o <= rd_data_i;
    end

    assign mst_o = '{active: mst_active, sram_sel: mst_sram_sel, page: mst_page,
                     abl: mst_abl, rwn: mst_rwn};

    // master keeps req up until it has seen ack
    assert property (@(posedge clk6x) disable iff (!resetn)
        $fell(req_i) |-> ack_o);

endmodule

// ==== verilog/membus_driver.sv ====
/*
 * Memory bus driver
 * chip selects, strobes, address and write data for the external bus,
 * and the registered read data back to the CPU
 */
`timescale 1ns/1ps

module membus_driver import nora_bus_pkg::*;
(
    input  logic       clk6x,
    input  logic       resetn,
    input  cpu_cycle_t cycle_i,
    input  mst_bus_t   mst_i,
    input  logic       release_wr_i,
    input  byte_t      cpu_db_i,
    input  byte_t      mst_data_i,
    input  byte_t      mem_db_i,
    input  byte_t      nora_slv_data_i,
    input  byte_t      bank_rd_i,
    input  logic       release_cs_i,
    input  low_addr_t  memcpu_abl_i,
    output mem_page_t  mem_abh_o,
    output low_addr_t  memcpu_abl_o,
    output logic       mem_rdn_o,
    output logic       mem_wrn_o,
    output logic       sram_csn_o,
    output logic       vera_csn_o,
    output logic       aura_csn_o,
    output logic       enet_csn_o,
    output logic       nora_slv_req_bootrom_o,
    output logic       nora_slv_req_scrb_o,
    output logic       nora_slv_req_via1_o,
    output cpu_addr_t  nora_slv_addr_o,
    output logic       nora_slv_rwn_o,
    output byte_t      mem_db_o,
    output byte_t      nora_slv_datawr_o,
    output logic       nora_slv_datawr_valid_o,
    output byte_t      cpu_db_o,
    output byte_t      rd_data_o
);

    logic  wr_released;
    logic  rom_cyc;
    logic  ext_sel;
    logic  rd_cyc;
    logic  wr_ok;
    byte_t wr_data;

    // wrn goes up on release_wr for hold time before the CS drops
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
            wr_released <= 1'b0;
        else if (release_cs_i)
            wr_released <= 1'b0;
        else if (release_wr_i)
            wr_released <= 1'b1;
    end

    // ROM banks are SRAM, but read-only for the CPU
    assign rom_cyc = (cycle_i.region == REG_SRAM) && (cycle_i.addr[15:14] == ROM_BASE);

    always_comb
    begin
        if (mst_i.active)
        begin
            ext_sel = mst_i.sram_sel;
            rd_cyc = mst_i.rwn;
            wr_ok = 1'b1;
        end
        else
        begin
            ext_sel = cycle_i.region inside {REG_SRAM, REG_VERA, REG_AURA, REG_ENET};
            rd_cyc = cycle_i.rwn;
            wr_ok = !rom_cyc && !wr_released;
        end
    end

    assign mem_rdn_o = !(ext_sel && rd_cyc);
    assign mem_wrn_o = !(ext_sel && !rd_cyc && wr_ok);

    // active-low selects, master owns only SRAM
    assign sram_csn_o = mst_i.active ? !mst_i.sram_sel : (cycle_i.region != REG_SRAM);
    assign vera_csn_o = mst_i.active || (cycle_i.region != REG_VERA);
    assign aura_csn_o = mst_i.active || (cycle_i.region != REG_AURA);
    assign enet_csn_o = mst_i.active || (cycle_i.region != REG_ENET);

    // internal slaves
    assign nora_slv_req_bootrom_o = (cycle_i.region == REG_BOOTROM);
    assign nora_slv_req_scrb_o = (cycle_i.region == REG_SCRB);
    assign nora_slv_req_via1_o = (cycle_i.region == REG_VIA1);
    assign nora_slv_addr_o = cycle_i.addr;
    assign nora_slv_rwn_o = cycle_i.rwn;

    assign mem_abh_o = mst_i.active ? mst_i.page : cycle_i.page;
    // outside any cycle the shared low lines mirror what the CPU drives
    assign memcpu_abl_o = mst_i.active ? mst_i.abl :
                          (cycle_i.region != REG_NONE) ? cycle_i.addr[11:0] : memcpu_abl_i;

    // write data, master first
    assign wr_data = mst_i.active ? mst_data_i : cpu_db_i;
    assign mem_db_o = wr_data;
    assign nora_slv_datawr_o = wr_data;
    // CPU write data only settles at the end of the cycle
    assign nora_slv_datawr_valid_o = release_cs_i;
    assign rd_data_o = mem_db_i;

    // read data to CPU, one cycle behind its source
    always_ff @(posedge clk6x)
    begin
        if (!mem_rdn_o)
            cpu_db_o <= mem_db_i;
        else if (cycle_i.region == REG_BANKREG)
            cpu_db_o <= bank_rd_i;
        else if (cycle_i.region inside {REG_BOOTROM, REG_SCRB, REG_VIA1})
            cpu_db_o <= nora_slv_data_i;
    end

    // master takes the bus only between CPU cycles
    assert property (@(posedge clk6x) disable iff (!resetn)
        mst_i.active |-> (cycle_i.region == REG_NONE));

endmodule

// ==== verilog/bus_controller.sv ====
/*
 * External CPU and memory bus controller
 * decodes CPU cycles, holds the bank registers, drives the memory bus
 * and serves debug-master SRAM accesses
 */
`timescale 1ns/1ps

module bus_controller import nora_bus_pkg::*;
#(
    parameter int ACCESS_WAIT = 2
)
(
    input  logic         clk6x,
    input  logic         resetn,
    // CPU bus
    output byte_t        cpu_db_o,
    input  byte_t        cpu_db_i,
    input  logic [15:12] cpu_abh_i,
    output logic         cpu_be_o,
    input  logic         cpu_rw_i,
    // memory bus
    output mem_page_t    mem_abh_o,
    output low_addr_t    memcpu_abl_o,
    input  low_addr_t    memcpu_abl_i,
    input  byte_t        mem_db_i,
    output byte_t        mem_db_o,
    output logic         mem_rdn_o,
    output logic         mem_wrn_o,
    output logic         sram_csn_o,
    output logic         vera_csn_o,
    output logic         aura_csn_o,
    output logic         enet_csn_o,
    // CPU clock phaser
    input  logic         setup_cs_i,
    input  logic         release_wr_i,
    input  logic         release_cs_i,
    output logic         run_cpu_o,
    input  logic         stopped_cpu_i,
    // debug master
    input  logic         nora_mst_req_i,
    input  mst_addr_t    nora_mst_addr_i,
    input  byte_t        nora_mst_data_i,
    input  logic         nora_mst_rwn_i,
    output byte_t        nora_mst_datard_o,
    output logic         nora_mst_ack_o,
    // internal slaves
    output cpu_addr_t    nora_slv_addr_o,
    output byte_t        nora_slv_datawr_o,
    output logic         nora_slv_datawr_valid_o,
    input  byte_t        nora_slv_data_i,
    output logic         nora_slv_req_bootrom_o,
    output logic         nora_slv_req_scrb_o,
    output logic         nora_slv_req_via1_o,
    output logic         nora_slv_rwn_o,
    // RAMBANK limit from SCRB
    input  ram_bank_t    rambank_mask_i
);

    cpu_cycle_t cycle;
    ram_bank_t  ram_bank_masked;
    rom_bank_t  rom_bank;
    byte_t      bank_rd;
    mst_bus_t   mst_bus;
    byte_t      mst_rd_data;

    cpu_cycle_decode u_decode (
        .clk6x             (clk6x),
        .resetn            (resetn),
        .setup_cs_i        (setup_cs_i),
        .release_cs_i      (release_cs_i),
        .cpu_abh_i         (cpu_abh_i),
        .memcpu_abl_i      (memcpu_abl_i),
        .cpu_rw_i          (cpu_rw_i),
        .ram_bank_masked_i (ram_bank_masked),
        .rom_bank_i        (rom_bank),
        .cycle_o           (cycle)
    );

    bank_regs u_banks (
        .clk6x             (clk6x),
        .resetn            (resetn),
        .release_wr_i      (release_wr_i),
        .db_wr_i           (cpu_db_i),
        .cycle_i           (cycle),
        .rambank_mask_i    (rambank_mask_i),
        .ram_bank_masked_o (ram_bank_masked),
        .rom_bank_o        (rom_bank),
        .bank_rd_o         (bank_rd)
    );

    master_access_fsm #(
        .ACCESS_WAIT (ACCESS_WAIT)
    ) u_master (
        .clk6x         (clk6x),
        .resetn        (resetn),
        .req_i         (nora_mst_req_i),
        .addr_i        (nora_mst_addr_i),
        .rwn_i         (nora_mst_rwn_i),
        .stopped_cpu_i (stopped_cpu_i),
        .rd_data_i     (mst_rd_data),
        .run_cpu_o     (run_cpu_o),
        .cpu_be_o      (cpu_be_o),
        .mst_o         (mst_bus),
        .ack_o         (nora_mst_ack_o),
        .datard_o      (nora_mst_datard_o)
    );

    membus_driver u_driver (
        .clk6x                   (clk6x),
        .resetn                  (resetn),
        .cycle_i                 (cycle),
        .mst_i                   (mst_bus),
        .release_wr_i            (release_wr_i),
        .cpu_db_i                (cpu_db_i),
        .mst_data_i              (nora_mst_data_i),
        .mem_db_i                (mem_db_i),
        .nora_slv_data_i         (nora_slv_data_i),
        .bank_rd_i               (bank_rd),
        .release_cs_i            (release_cs_i),
        .memcpu_abl_i            (memcpu_abl_i),
        .mem_abh_o               (mem_abh_o),
        .memcpu_abl_o            (memcpu_abl_o),
        .mem_rdn_o               (mem_rdn_o),
        .mem_wrn_o               (mem_wrn_o),
        .sram_csn_o              (sram_csn_o),
        .vera_csn_o              (vera_csn_o),
        .aura_csn_o              (aura_csn_o),
        .enet_csn_o              (enet_csn_o),
        .nora_slv_req_bootrom_o  (nora_slv_req_bootrom_o),
        .nora_slv_req_scrb_o     (nora_slv_req_scrb_o),
        .nora_slv_req_via1_o     (nora_slv_req_via1_o),
        .nora_slv_addr_o         (nora_slv_addr_o),
        .nora_slv_rwn_o          (nora_slv_rwn_o),
        .mem_db_o                (mem_db_o),
        .nora_slv_datawr_o       (nora_slv_datawr_o),
        .nora_slv_datawr_valid_o (nora_slv_datawr_valid_o),
        .cpu_db_o                (cpu_db_o),
        .rd_data_o               (mst_rd_data)
    );

endmodule

// ==== bench/tb_bus_controller.sv ====
/*
 * testbench for the external bus controller
 * runs CPU cycles through the phaser strobes and debug-master SRAM accesses,
 * checks the bus with immediate and concurrent assertions
 */
`timescale 1ns/1ps

module tb_bus_controller import nora_bus_pkg::*;
();

    localparam int          ACCESS_WAIT = 2;
    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] RNG_SEED = 32'h7d91_ee3a;
    // clock periods per CPU cycle and per master access, worst case
    localparam int          CPU_CYC_LEN = 6;
    localparam int          MST_LEN = 60;
    localparam int          RUN_CYCLES = 10 + 18 * CPU_CYC_LEN + 2 * MST_LEN;
    localparam int          WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

    logic clk6x, resetn;
    byte_t cpu_db_o, cpu_db_i, mem_db_i, mem_db_o;
    logic [15:12] cpu_abh_i;
    logic cpu_be_o, cpu_rw_i;
    mem_page_t mem_abh_o;
    low_addr_t memcpu_abl_o, memcpu_abl_i;
    logic mem_rdn_o, mem_wrn_o, sram_csn_o, vera_csn_o, aura_csn_o, enet_csn_o;
    logic setup_cs_i, release_wr_i, release_cs_i, run_cpu_o, stopped_cpu_i;
    logic nora_mst_req_i, nora_mst_rwn_i, nora_mst_ack_o;
    mst_addr_t nora_mst_addr_i;
    byte_t nora_mst_data_i, nora_mst_datard_o;
    cpu_addr_t nora_slv_addr_o;
    byte_t nora_slv_datawr_o, nora_slv_data_i;
    logic nora_slv_datawr_valid_o, nora_slv_rwn_o;
    logic nora_slv_req_bootrom_o, nora_slv_req_scrb_o, nora_slv_req_via1_o;
    ram_bank_t rambank_mask_i;

    int tests;
    int checks;
    int errors;
    // high while a CPU write goes into the ROM window
    logic rom_window;
    // bus state seen mid-cycle and at the end of the last CPU cycle
    mem_page_t snap_abh;
    logic [6:0] snap_sel;
    logic snap_wrn, snap_wrn_rel;
    logic snap_rdn;
    cpu_addr_t snap_slv_addr;
    logic snap_slv_rwn;
    byte_t snap_slv_wr;
    byte_t snap_db;

    bus_controller #(.ACCESS_WAIT(ACCESS_WAIT)) UUT (.*);

    initial
    begin
        clk6x = 1'b0;
        forever #(CLK_PERIOD / 2) clk6x = ~clk6x;
    end

    // CPU only loses the bus once it has been told to stop
    assert property (@(posedge clk6x) disable iff (!resetn) !cpu_be_o |-> !run_cpu_o)
    else
    begin
        errors++;
        $display("cpu_be_o went low while run_cpu_o was still high");
    end

    assert property (@(posedge clk6x) disable iff (!resetn) nora_mst_ack_o |-> cpu_be_o)
    else
    begin
        errors++;
        $display("nora_mst_ack_o high while the CPU bus was still disabled");
    end

    // ROM window is read-only for the CPU
    assert property (@(posedge clk6x) disable iff (!resetn) rom_window |-> mem_wrn_o)
    else
    begin
        errors++;
        $display("mem_wrn_o went low on a CPU write into the ROM window");
    end

    assert property (@(posedge clk6x) disable iff (!resetn)
        release_cs_i |=> (sram_csn_o && vera_csn_o && aura_csn_o && enet_csn_o
            && !nora_slv_req_bootrom_o && !nora_slv_req_scrb_o && !nora_slv_req_via1_o
            && mem_rdn_o && mem_wrn_o))
    else
    begin
        errors++;
        $display("a select or strobe stayed active one cycle after release_cs_i");
    end

    assert property (@(posedge clk6x) disable iff (!resetn)
        nora_slv_datawr_valid_o == release_cs_i)
    else
    begin
        errors++;
        $display("Fail nora_slv_datawr_valid_o got %h exp %h",
                 $sampled(nora_slv_datawr_valid_o), $sampled(release_cs_i));
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    // active high {sram, vera, aura, enet, bootrom, scrb, via1}
    function automatic logic [6:0] sel_vec();
        sel_vec = {!sram_csn_o, !vera_csn_o, !aura_csn_o, !enet_csn_o,
                   nora_slv_req_bootrom_o, nora_slv_req_scrb_o, nora_slv_req_via1_o};
    endfunction

    // next drive point, 2 ns after the rising edge
    task automatic step();
        @(posedge clk6x);
        #2;
    endtask

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Fail %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_start);
    endtask

    // one phaser cycle: setup_cs, release_wr, release_cs, one idle cycle
    task automatic cpu_cycle(input cpu_addr_t addr, input logic rwn, input byte_t wdata);
        cpu_abh_i = addr[15:12];
        memcpu_abl_i = addr[11:0];
        cpu_rw_i = rwn;
        cpu_db_i = wdata;
        setup_cs_i = 1'b1;
        step();
        setup_cs_i = 1'b0;
        @(negedge clk6x);
        snap_abh = mem_abh_o;
        snap_sel = sel_vec();
        snap_wrn = mem_wrn_o;
        snap_rdn = mem_rdn_o;
        snap_slv_addr = nora_slv_addr_o;
        snap_slv_rwn = nora_slv_rwn_o;
        step();
        release_wr_i = 1'b1;
        step();
        release_wr_i = 1'b0;
        release_cs_i = 1'b1;
        @(negedge clk6x);
        snap_wrn_rel = mem_wrn_o;
        snap_slv_wr = nora_slv_datawr_o;
        snap_db = cpu_db_o;
        step();
        release_cs_i = 1'b0;
        step();
    endtask

    task automatic decode_check(input cpu_addr_t addr, input logic [6:0] exp_sel);
        cpu_cycle(addr, 1'b1, 8'h00);
        check_hex("sel {sram,vera,aura,enet,bootrom,scrb,via1}", snap_sel, exp_sel);
        check_hex("nora_slv_addr_o", snap_slv_addr, addr);
        check_hex("nora_slv_rwn_o", snap_slv_rwn, 1'b1);
    endtask

    task automatic master_access(input mst_addr_t addr, input logic rwn,
                                 input byte_t wdata, input byte_t rdata);
        int n;
        logic be_low;
        logic seen_sel;
        byte_t bus_db;
        logic bus_wrn;
        mem_page_t bus_abh;
        low_addr_t bus_abl;
        be_low = 1'b1;
        seen_sel = 1'b0;
        bus_db = '0;
        bus_wrn = 1'b1;
        bus_abh = '0;
        bus_abl = '0;
        mem_db_i = rdata;
        nora_mst_addr_i = addr;
        nora_mst_rwn_i = rwn;
        nora_mst_data_i = wdata;
        nora_mst_req_i = 1'b1;
        n = 0;
        while (run_cpu_o && n < 10)
        begin
            step();
            n++;
        end
        if (run_cpu_o)
        begin
            errors++;
            $display("run_cpu_o did not fall after the master request");
        end
        // phaser needs a varying time to park the CPU
        repeat ($urandom_range(1, 4)) step();
        stopped_cpu_i = 1'b1;
        @(posedge clk6x);
        #1;
        n = 0;
        while (!nora_mst_ack_o && n < 20)
        begin
            if (cpu_be_o)
                be_low = 1'b0;
            if (!sram_csn_o)
            begin
                seen_sel = 1'b1;
                bus_db = mem_db_o;
                bus_wrn = mem_wrn_o;
                bus_abh = mem_abh_o;
                bus_abl = memcpu_abl_o;
            end
            @(posedge clk6x);
            #1;
            n++;
        end
        #1;
        if (!nora_mst_ack_o)
        begin
            errors++;
            $display("nora_mst_ack_o never rose during the master access");
        end
        // counted from the edge that saw stopped_cpu_i high
        check_hex("nora_mst_ack_o rise edge", n, 4 + ACCESS_WAIT);
        check_hex("cpu_be_o", cpu_be_o, 1'b1);
        if (!be_low)
        begin
            errors++;
            $display("cpu_be_o was high during the master access");
        end
        if (!seen_sel)
        begin
            errors++;
            $display("master access never selected the SRAM");
        end
        check_hex("mem_abh_o", bus_abh, addr[20:12]);
        check_hex("memcpu_abl_o", bus_abl, addr[11:0]);
        check_hex("mem_wrn_o", bus_wrn, rwn);
        if (!rwn)
            check_hex("mem_db_o", bus_db, wdata);
        else
            check_hex("nora_mst_datard_o", nora_mst_datard_o, rdata);
        // second half of the four-phase handshake
        stopped_cpu_i = 1'b0;
        nora_mst_req_i = 1'b0;
        n = 0;
        while (nora_mst_ack_o && n < 10)
        begin
            step();
            n++;
        end
        check_hex("nora_mst_ack_o fall cycles", n, 1);
        check_hex("run_cpu_o", run_cpu_o, 1'b1);
    endtask

    initial
    begin
        int err_start;
        byte_t v;
        byte_t mask;
        byte_t rd;
        byte_t wd;
        byte_t b;
        low_addr_t low12;
        logic [13:0] low14;
        logic [3:0] nib;
        cpu_addr_t a;
        void'($urandom(RNG_SEED));
        tests = 0;
        checks = 0;
        errors = 0;
        rom_window = 1'b0;
        resetn = 1'b0;
        cpu_db_i = '0;
        cpu_abh_i = '0;
        cpu_rw_i = 1'b1;
        memcpu_abl_i = '0;
        mem_db_i = '0;
        setup_cs_i = 1'b0;
        release_wr_i = 1'b0;
        release_cs_i = 1'b0;
        stopped_cpu_i = 1'b0;
        nora_mst_req_i = 1'b0;
        nora_mst_addr_i = '0;
        nora_mst_data_i = '0;
        nora_mst_rwn_i = 1'b1;
        nora_slv_data_i = '0;
        rambank_mask_i = 8'hFF;
        repeat (5) @(posedge clk6x);
        #2;
        resetn = 1'b1;

        err_start = errors;
        @(negedge clk6x);
        check_hex("sel {sram,vera,aura,enet,bootrom,scrb,via1}", sel_vec(), 7'b0);
        check_hex("mem_rdn_o", mem_rdn_o, 1'b1);
        check_hex("mem_wrn_o", mem_wrn_o, 1'b1);
        check_hex("cpu_be_o", cpu_be_o, 1'b1);
        check_hex("nora_mst_ack_o", nora_mst_ack_o, 1'b0);
        step();
        finish_test("reset state", err_start);

        // RAMBANK write, masked page, read back unmasked
        err_start = errors;
        mask = 8'($urandom);
        v = 8'($urandom);
        rambank_mask_i = mask;
        cpu_cycle(16'h0000, 1'b0, v);
        rd = 8'($urandom);
        mem_db_i = rd;
        low12 = 12'($urandom);
        cpu_cycle({4'hA, low12}, 1'b1, 8'h00);
        check_hex("mem_abh_o", snap_abh, {v & mask, 1'b0});
        check_hex("sel {sram,vera,aura,enet,bootrom,scrb,via1}", snap_sel, 7'b1000000);
        check_hex("mem_rdn_o", snap_rdn, 1'b0);
        check_hex("cpu_db_o", snap_db, rd);
        cpu_cycle({4'hB, low12}, 1'b1, 8'h00);
        check_hex("mem_abh_o", snap_abh, {v & mask, 1'b1});
        cpu_cycle(16'h0000, 1'b1, 8'h00);
        check_hex("cpu_db_o", snap_db, v);
        finish_test("ram bank", err_start);

        // ROMBANK in SRAM, then the boot ROM with bit 5 set
        err_start = errors;
        b = 8'($urandom);
        b[5] = 1'b0;
        cpu_cycle(16'h0001, 1'b0, b);
        low14 = 14'($urandom);
        a = {2'b11, low14};
        cpu_cycle(a, 1'b1, 8'h00);
        check_hex("mem_abh_o", snap_abh, {2'b11, b[4:0], a[13:12]});
        check_hex("sel {sram,vera,aura,enet,bootrom,scrb,via1}", snap_sel, 7'b1000000);
        rom_window = 1'b1;
        cpu_cycle(a, 1'b0, 8'($urandom));
        rom_window = 1'b0;
        check_hex("mem_wrn_o", snap_wrn, 1'b1);
        cpu_cycle(16'h0001, 1'b1, 8'h00);
        check_hex("cpu_db_o", snap_db, {2'b00, b[5:0]});
        b[5] = 1'b1;
        cpu_cycle(16'h0001, 1'b0, b);
        rd = 8'($urandom);
        nora_slv_data_i = rd;
        cpu_cycle(a, 1'b1, 8'h00);
        check_hex("sel {sram,vera,aura,enet,bootrom,scrb,via1}", snap_sel, 7'b0000100);
        check_hex("cpu_db_o", snap_db, rd);
        finish_test("rom bank", err_start);

        // I/O slots, one device each, then low memory
        err_start = errors;
        decode_check(16'h9F00 | 16'($urandom_range(0, 15)), 7'b0000001);
        decode_check(16'h9F20 | 16'($urandom_range(0, 15)), 7'b0100000);
        decode_check(16'h9F40 | 16'($urandom_range(0, 15)), 7'b0010000);
        decode_check(16'h9F50 | 16'($urandom_range(0, 15)), 7'b0000010);
        decode_check(16'h9F80 | 16'($urandom_range(0, 15)), 7'b0001000);
        nib = 4'($urandom_range(1, 8));
        low12 = 12'($urandom);
        a = {nib, low12};
        cpu_cycle(a, 1'b1, 8'h00);
        check_hex("mem_abh_o", snap_abh, 9'h170 + nib);
        check_hex("sel {sram,vera,aura,enet,bootrom,scrb,via1}", snap_sel, 7'b1000000);
        wd = 8'($urandom);
        cpu_cycle(a, 1'b0, wd);
        check_hex("mem_wrn_o", snap_wrn, 1'b0);
        check_hex("mem_wrn_o", snap_wrn_rel, 1'b1);
        check_hex("nora_slv_rwn_o", snap_slv_rwn, 1'b0);
        check_hex("nora_slv_datawr_o", snap_slv_wr, wd);
        finish_test("io and low memory", err_start);

        // debug master, write then read
        err_start = errors;
        master_access(21'($urandom), 1'b0, 8'($urandom), 8'($urandom));
        step();
        master_access(21'($urandom), 1'b1, 8'($urandom), 8'($urandom));
        finish_test("master access", err_start);

        repeat (3) step();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/nora_bus_pkg.sv
verilog/cpu_cycle_decode.sv
verilog/bank_regs.sv
verilog/master_access_fsm.sv
verilog/membus_driver.sv
verilog/bus_controller.sv
bench/tb_bus_controller.sv

// ==== Bender.yml ====
package:
  name: bus_controller

sources:
  # package first, then leaf blocks, then the top level
  - verilog/nora_bus_pkg.sv
  - verilog/cpu_cycle_decode.sv
  - verilog/bank_regs.sv
  - verilog/master_access_fsm.sv
  - verilog/membus_driver.sv
  - verilog/bus_controller.sv
  - target: simulation
    files:
      - bench/tb_bus_controller.sv
